//--- alu.sv
// Combinational integer ALU of the execute stage, also producing branch compare results
`default_nettype none

module alu (
    input  logic [core_pkg::XLEN-1:0] operand_a_i,
    input  logic [core_pkg::XLEN-1:0] operand_b_i,
    input  core_pkg::alu_operation_t  operation_i,
    output logic [core_pkg::XLEN-1:0] result_o
);

    import core_pkg::*;

    // Shift amount from low 5 bits of b
    logic [4:0] shamt;

    // Shared compare terms
    logic equal;
    logic less_signed;
    logic less_unsigned;

    assign shamt         = operand_b_i[4:0];
    assign equal         = (operand_a_i == operand_b_i);
    assign less_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
    assign less_unsigned = (operand_a_i < operand_b_i);

    always_comb begin
        result_o = '0;
        case (operation_i)
            // Arithmetic
            ALU_ADD: result_o = operand_a_i + operand_b_i;
            ALU_SUB: result_o = operand_a_i - operand_b_i;

            // Logic
            ALU_AND: result_o = operand_a_i & operand_b_i;
            ALU_OR:  result_o = operand_a_i | operand_b_i;
            ALU_XOR: result_o = operand_a_i ^ operand_b_i;

            // Shifts
            ALU_SLL: result_o = operand_a_i << shamt;
            ALU_SRL: result_o = operand_a_i >> shamt;
            ALU_SRA: result_o = $unsigned($signed(operand_a_i) >>> shamt);

            // Set-less-than for rd writeback
            ALU_SLT:  result_o[0] = less_signed;
            ALU_SLTU: result_o[0] = less_unsigned;

            // Branch compares, decision taken from bit 0
            ALU_EQ:  result_o[0] = equal;
            ALU_NE:  result_o[0] = ~equal;
            ALU_LT:  result_o[0] = less_signed;
            ALU_GE:  result_o[0] = ~less_signed;
            ALU_LTU: result_o[0] = less_unsigned;
            ALU_GEU: result_o[0] = ~less_unsigned;

            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- compile.f
core_pkg.sv
csr_pkg.sv
alu.sv
ex_stage.sv
csr_unit.sv
ex_top.sv
tb_clkgen.sv
tb_ex_top.sv

//--- core_pkg.sv
// Datapath types and word width shared by the execute stage RTL and its testbench
`default_nettype none

package core_pkg;

    ////////////////////
    // Word width
    ////////////////////

    localparam int XLEN = 32;

    ////////////////////
    // ALU operations
    ////////////////////

    // Compare operations return 0 or 1 in bit 0
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_EQ,
        ALU_NE,
        ALU_LT,
        ALU_GE,
        ALU_LTU,
        ALU_GEU
    } alu_operation_t;

    // Load and store width, carried through EX toward MEM
    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } data_type_t;

    // Next PC selection, carried through EX back to IF
    typedef enum logic [1:0] {
        PC_NEXT,
        PC_BRANCH,
        PC_TRAP
    } pc_source_t;

endpackage

`default_nettype wire

//--- csr_pkg.sv
// Machine CSR space types and the operand-2 view used by the execute stage and CSR unit
`default_nettype none

package csr_pkg;

    // Implemented machine CSRs only
    typedef enum logic [11:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342
    } csr_addr_t;

    // Zicsr style access kinds
    typedef enum logic [1:0] {
        CSR_READ,
        CSR_WRITE,
        CSR_SET,
        CSR_CLEAR
    } csr_operation_t;

    ////////////////////
    // Operand 2 decode
    ////////////////////

    // Same word seen as ALU data or as a CSR address in the low 12 bits
    typedef union packed {
        logic [core_pkg::XLEN-1:0] data;
        struct packed {
            logic [core_pkg::XLEN-13:0] reserved;
            csr_addr_t                  addr;
        } csr;
    } csr_operand_u;

    // mcause code for a misaligned instruction address
    localparam logic [core_pkg::XLEN-1:0] CAUSE_INSTR_MISALIGNED = '0;

endpackage

`default_nettype wire

//--- csr_unit.sv
// Machine-mode CSR storage serving EX-stage accesses and capturing misaligned-branch traps
`default_nettype none

module csr_unit (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        stall_i,
    input  logic                        valid_i,
    input  logic                        access_i,
    input  csr_pkg::csr_operation_t     op_i,
    input  csr_pkg::csr_addr_t          addr_i,
    input  logic [core_pkg::XLEN-1:0]   wdata_i,
    input  logic [core_pkg::XLEN-1:0]   pc_i,
    input  logic                        trap_i,
    output logic                        access_o,
    output logic [core_pkg::XLEN-1:0]   rdata_o
);

    import core_pkg::*;
    import csr_pkg::*;

    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;

    logic            implemented;
    logic [XLEN-1:0] wdata_new;
    logic            write_en;

    ////////////////////
    // Read side
    ////////////////////

    // Old value, decoded combinationally
    always_comb begin
        implemented = 1'b1;
        rdata_o     = '0;
        case (addr_i)
            CSR_MSTATUS:  rdata_o = mstatus;
            CSR_MTVEC:    rdata_o = mtvec;
            CSR_MSCRATCH: rdata_o = mscratch;
            CSR_MEPC:     rdata_o = mepc;
            CSR_MCAUSE:   rdata_o = mcause;
            default:      implemented = 1'b0;
        endcase
    end

    assign access_o = valid_i & access_i & implemented;

    // New value per access kind
    always_comb begin
        case (op_i)
            CSR_WRITE: wdata_new = wdata_i;
            CSR_SET:   wdata_new = rdata_o | wdata_i;
            CSR_CLEAR: wdata_new = rdata_o & ~wdata_i;
            default:   wdata_new = rdata_o;
        endcase
    end

    // Commit only once per instruction
    assign write_en = access_o & ~stall_i & (op_i != CSR_READ);

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mstatus  <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (trap_i && !stall_i) begin
            // Trap capture, mepc kept word aligned
            mepc   <= {pc_i[XLEN-1:2], 2'b00};
            mcause <= CAUSE_INSTR_MISALIGNED;
        end else if (write_en) begin
            case (addr_i)
                CSR_MSTATUS:  mstatus  <= wdata_new;
                CSR_MTVEC:    mtvec    <= wdata_new;
                CSR_MSCRATCH: mscratch <= wdata_new;
                CSR_MEPC:     mepc     <= {wdata_new[XLEN-1:2], 2'b00};
                CSR_MCAUSE:   mcause   <= wdata_new;
                default:      mstatus  <= mstatus;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- ex_stage.sv
// Execute stage with ID-to-EX register, ALU, CSR read muxing, branch decision and trap
`default_nettype none

module ex_stage #(
    parameter bit ISA_C = 1'b0
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,

    // To IF
    output core_pkg::pc_source_t        pc_source_ex_o,
    output logic [core_pkg::XLEN-1:0]   branch_target_ex_o,
    output logic                        branch_decision_ex_o,
    output logic                        trap_ex_o,

    // From ID
    input  core_pkg::alu_operation_t    alu_operation_id_i,
    input  logic [4:0]                  rd_addr_id_i,
    input  logic                        mem_wen_id_i,
    input  core_pkg::data_type_t        mem_data_type_id_i,
    input  logic                        mem_sign_extend_id_i,
    input  logic                        reg_alu_wen_id_i,
    input  logic                        reg_mem_wen_id_i,
    input  logic [core_pkg::XLEN-1:0]   pc_id_i,
    input  core_pkg::pc_source_t        pc_source_id_i,
    input  logic                        is_branch_id_i,
    input  logic [core_pkg::XLEN-1:0]   alu_operand_1_id_i,
    input  logic [core_pkg::XLEN-1:0]   alu_operand_2_id_i,
    input  logic [core_pkg::XLEN-1:0]   mem_wdata_id_i,
    input  logic [core_pkg::XLEN-1:0]   branch_target_id_i,
    input  logic                        valid_id_i,
    input  logic                        csr_access_id_i,
    input  csr_pkg::csr_operation_t     csr_op_id_i,

    // To MEM
    output logic [4:0]                  rd_addr_ex_o,
    output logic [core_pkg::XLEN-1:0]   alu_result_ex_o,
    output logic                        mem_wen_ex_o,
    output core_pkg::data_type_t        mem_data_type_ex_o,
    output logic                        mem_sign_extend_ex_o,
    output logic [core_pkg::XLEN-1:0]   mem_wdata_ex_o,
    output logic                        reg_alu_wen_ex_o,
    output logic                        reg_mem_wen_ex_o,
    output logic                        valid_ex_o,

    // To CSR unit
    output logic [core_pkg::XLEN-1:0]   pc_ex_o,
    output csr_pkg::csr_addr_t          csr_addr_ex_o,
    output logic [core_pkg::XLEN-1:0]   csr_wdata_ex_o,
    output csr_pkg::csr_operation_t     csr_op_ex_o,
    output logic                        csr_access_ex_o,

    // From CSR unit
    input  logic                        csr_access_ex_i,
    input  logic [core_pkg::XLEN-1:0]   csr_rdata_ex_i,

    // Pipeline control
    input  logic                        stall_ex_i,
    input  logic                        flush_ex_i
);

    import core_pkg::*;
    import csr_pkg::*;

    alu_operation_t    alu_operation_ex;
    logic [XLEN-1:0]   alu_operand_1_ex;
    logic [XLEN-1:0]   alu_operand_2_ex;
    logic [XLEN-1:0]   alu_result_ex;
    logic              is_branch_ex;
    logic              target_misaligned;
    csr_operand_u      operand_2_id;

    // Operand 2 doubles as CSR address
    assign operand_2_id = alu_operand_2_id_i;

    ////////////////////
    // ID to EX register
    ////////////////////

    // Control fields, stall beats flush
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_ex_o       <= 1'b0;
            mem_wen_ex_o     <= 1'b0;
            reg_alu_wen_ex_o <= 1'b0;
            reg_mem_wen_ex_o <= 1'b0;
            is_branch_ex     <= 1'b0;
            csr_access_ex_o  <= 1'b0;
            csr_op_ex_o      <= CSR_READ;
            pc_source_ex_o   <= PC_NEXT;
        end else if (!stall_ex_i) begin
            if (flush_ex_i) begin
                // Bubble, data left as is
                valid_ex_o       <= 1'b0;
                mem_wen_ex_o     <= 1'b0;
                reg_alu_wen_ex_o <= 1'b0;
                reg_mem_wen_ex_o <= 1'b0;
                is_branch_ex     <= 1'b0;
                csr_access_ex_o  <= 1'b0;
            end else begin
                valid_ex_o       <= valid_id_i;
                mem_wen_ex_o     <= mem_wen_id_i;
                reg_alu_wen_ex_o <= reg_alu_wen_id_i;
                reg_mem_wen_ex_o <= reg_mem_wen_id_i;
                is_branch_ex     <= is_branch_id_i;
                csr_access_ex_o  <= csr_access_id_i;
                pc_source_ex_o   <= pc_source_id_i;
                if (csr_access_id_i) begin
                    csr_op_ex_o <= csr_op_id_i;
                end
            end
        end
    end

    // Payload fields, loaded only on a real advance
    always_ff @(posedge clk_i) begin
        if (!stall_ex_i && !flush_ex_i) begin
            alu_operation_ex     <= alu_operation_id_i;
            alu_operand_1_ex     <= alu_operand_1_id_i;
            alu_operand_2_ex     <= alu_operand_2_id_i;
            rd_addr_ex_o         <= rd_addr_id_i;
            mem_data_type_ex_o   <= mem_data_type_id_i;
            mem_sign_extend_ex_o <= mem_sign_extend_id_i;
            mem_wdata_ex_o       <= mem_wdata_id_i;
            pc_ex_o              <= pc_id_i;
            branch_target_ex_o   <= branch_target_id_i;
            // CSR write data from op 1, address from op 2
            if (csr_access_id_i) begin
                csr_wdata_ex_o <= alu_operand_1_id_i;
                csr_addr_ex_o  <= operand_2_id.csr.addr;
            end
        end
    end

    ////////////////////
    // Execute
    ////////////////////

    alu alu_i (
        .operand_a_i (alu_operand_1_ex),
        .operand_b_i (alu_operand_2_ex),
        .operation_i (alu_operation_ex),
        .result_o    (alu_result_ex)
    );

    // CSR read data replaces ALU result on ack
    assign alu_result_ex_o = csr_access_ex_i ? csr_rdata_ex_i : alu_result_ex;

    // Taken when compare bit 0 set
    assign branch_decision_ex_o = is_branch_ex & alu_result_ex_o[0];

    // Only 4-byte targets legal without C
    always_comb begin
        if (ISA_C) begin
            target_misaligned = 1'b0;
        end else begin
            target_misaligned = branch_decision_ex_o & branch_target_ex_o[1];
        end
    end

    assign trap_ex_o = valid_ex_o & target_misaligned;

endmodule

`default_nettype wire

//--- ex_top.sv
// Top level joining the execute stage and the CSR unit, with ISA_C passed down
`default_nettype none

module ex_top #(
    parameter bit ISA_C = 1'b0
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    output core_pkg::pc_source_t        pc_source_ex_o,
    output logic [core_pkg::XLEN-1:0]   branch_target_ex_o,
    output logic                        branch_decision_ex_o,
    output logic                        trap_ex_o,
    input  core_pkg::alu_operation_t    alu_operation_id_i,
    input  logic [4:0]                  rd_addr_id_i,
    input  logic                        mem_wen_id_i,
    input  core_pkg::data_type_t        mem_data_type_id_i,
    input  logic                        mem_sign_extend_id_i,
    input  logic                        reg_alu_wen_id_i,
    input  logic                        reg_mem_wen_id_i,
    input  logic [core_pkg::XLEN-1:0]   pc_id_i,
    input  core_pkg::pc_source_t        pc_source_id_i,
    input  logic                        is_branch_id_i,
    input  logic [core_pkg::XLEN-1:0]   alu_operand_1_id_i,
    input  logic [core_pkg::XLEN-1:0]   alu_operand_2_id_i,
    input  logic [core_pkg::XLEN-1:0]   mem_wdata_id_i,
    input  logic [core_pkg::XLEN-1:0]   branch_target_id_i,
    input  logic                        valid_id_i,
    input  logic                        csr_access_id_i,
    input  csr_pkg::csr_operation_t     csr_op_id_i,
    output logic [4:0]                  rd_addr_ex_o,
    output logic [core_pkg::XLEN-1:0]   alu_result_ex_o,
    output logic                        mem_wen_ex_o,
    output core_pkg::data_type_t        mem_data_type_ex_o,
    output logic                        mem_sign_extend_ex_o,
    output logic [core_pkg::XLEN-1:0]   mem_wdata_ex_o,
    output logic                        reg_alu_wen_ex_o,
    output logic                        reg_mem_wen_ex_o,
    output logic                        valid_ex_o,
    input  logic                        stall_ex_i,
    input  logic                        flush_ex_i
);

    import core_pkg::*;
    import csr_pkg::*;

    // EX to CSR request
    logic [XLEN-1:0] pc_ex;
    csr_addr_t       csr_addr_ex;
    logic [XLEN-1:0] csr_wdata_ex;
    csr_operation_t  csr_op_ex;
    logic            csr_access_ex;

    // CSR to EX answer, same cycle
    logic            csr_ack_ex;
    logic [XLEN-1:0] csr_rdata_ex;

    ex_stage #(
        .ISA_C (ISA_C)
    ) ex_stage_i (
        .clk_i                (clk_i),
        .rst_n_i              (rst_n_i),
        .pc_source_ex_o       (pc_source_ex_o),
        .branch_target_ex_o   (branch_target_ex_o),
        .branch_decision_ex_o (branch_decision_ex_o),
        .trap_ex_o            (trap_ex_o),
        .alu_operation_id_i   (alu_operation_id_i),
        .rd_addr_id_i         (rd_addr_id_i),
        .mem_wen_id_i         (mem_wen_id_i),
        .mem_data_type_id_i   (mem_data_type_id_i),
        .mem_sign_extend_id_i (mem_sign_extend_id_i),
        .reg_alu_wen_id_i     (reg_alu_wen_id_i),
        .reg_mem_wen_id_i     (reg_mem_wen_id_i),
        .pc_id_i              (pc_id_i),
        .pc_source_id_i       (pc_source_id_i),
        .is_branch_id_i       (is_branch_id_i),
        .alu_operand_1_id_i   (alu_operand_1_id_i),
        .alu_operand_2_id_i   (alu_operand_2_id_i),
        .mem_wdata_id_i       (mem_wdata_id_i),
        .branch_target_id_i   (branch_target_id_i),
        .valid_id_i           (valid_id_i),
        .csr_access_id_i      (csr_access_id_i),
        .csr_op_id_i          (csr_op_id_i),
        .rd_addr_ex_o         (rd_addr_ex_o),
        .alu_result_ex_o      (alu_result_ex_o),
        .mem_wen_ex_o         (mem_wen_ex_o),
        .mem_data_type_ex_o   (mem_data_type_ex_o),
        .mem_sign_extend_ex_o (mem_sign_extend_ex_o),
        .mem_wdata_ex_o       (mem_wdata_ex_o),
        .reg_alu_wen_ex_o     (reg_alu_wen_ex_o),
        .reg_mem_wen_ex_o     (reg_mem_wen_ex_o),
        .valid_ex_o           (valid_ex_o),
        .pc_ex_o              (pc_ex),
        .csr_addr_ex_o        (csr_addr_ex),
        .csr_wdata_ex_o       (csr_wdata_ex),
        .csr_op_ex_o          (csr_op_ex),
        .csr_access_ex_o      (csr_access_ex),
        .csr_access_ex_i      (csr_ack_ex),
        .csr_rdata_ex_i       (csr_rdata_ex),
        .stall_ex_i           (stall_ex_i),
        .flush_ex_i           (flush_ex_i)
    );

    csr_unit csr_unit_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .stall_i  (stall_ex_i),
        .valid_i  (valid_ex_o),
        .access_i (csr_access_ex),
        .op_i     (csr_op_ex),
        .addr_i   (csr_addr_ex),
        .wdata_i  (csr_wdata_ex),
        .pc_i     (pc_ex),
        .trap_i   (trap_ex_o),
        .access_o (csr_ack_ex),
        .rdata_o  (csr_rdata_ex)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the execute-stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary -f compile.f --top-module tb_ex_top -o sim_tb

./obj_dir/sim_tb | tee sim.log

# Pass only when the pass message is in the log
grep -q "Test completed successfully" sim.log

//--- tb_clkgen.sv
// Testbench clock and reset source, 8 ns clock with reset held low for 3 cycles
`default_nettype none

module tb_clkgen (
    output logic clk_o,
    output logic rst_n_o
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // Release away from the rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- tb_ex_top.sv
// Self-checking testbench for ex_top, acting as decode and comparing EX outputs to a model
`default_nettype none

module tb_ex_top;

    timeunit 1ns;
    timeprecision 100ps;

    import core_pkg::*;
    import csr_pkg::*;

    typedef struct {
        int          due;
        int          test;
        logic        loaded;
        logic [31:0] res;
        logic        valid;
        logic        dec;
        logic        trap;
        logic [31:0] target;
        logic        wen;
        logic        lwen;
        logic [4:0]  rd;
        logic [31:0] wdata;
        logic [1:0]  dtype;
        logic        sext;
        logic [1:0]  pcsrc;
    } expect_t;

    // Test lengths in cycles, for the timeout
    localparam int LEN_RESET  = 10;
    localparam int LEN_ALU    = 203;
    localparam int LEN_STALL  = 16;
    localparam int LEN_BRANCH = 43;
    localparam int LEN_TRAP   = 10;
    localparam int LEN_CSR    = 20;
    localparam int CYCLE_LIMIT =
        2 * (LEN_RESET + LEN_ALU + LEN_STALL + LEN_BRANCH + LEN_TRAP + LEN_CSR);

    logic clk, rst_n;
    alu_operation_t alu_op;
    logic [31:0] op1, op2, target, pc;
    logic is_br, valid, access, wen, lwen, stall, flush;
    logic [4:0] rd;
    logic sext;
    data_type_t dtype;
    pc_source_t pc_src;
    csr_operation_t cop;
    pc_source_t pc_src_o;
    logic [31:0] target_o, result_o, mem_wdata_o;
    logic dec_o, trap_o, valid_o, mem_wen_o, alu_wen_o, mem_rwen_o, sext_o;
    logic [4:0] rd_o;
    data_type_t dtype_o;

    // Model of the EX register and shadow CSRs
    alu_operation_t m_op;
    logic [31:0] m_a, m_b, m_target, m_pc, m_cwdata;
    logic [11:0] m_caddr;
    csr_operation_t m_cop;
    logic m_valid, m_wen, m_lwen, m_branch, m_access, m_loaded;
    logic [4:0] m_rd;
    logic [1:0] m_dtype, m_pcsrc;
    logic m_sext;
    logic [31:0] shadow [5];

    expect_t exp_q[$];
    int cycle, checks, errors, test_errs;
    logic [31:0] lfsr;
    string names [6];

    tb_clkgen tb_clkgen_i (.clk_o(clk), .rst_n_o(rst_n));

    ex_top #(.ISA_C(1'b0)) ex_top_i (
        .clk_i(clk), .rst_n_i(rst_n),
        .pc_source_ex_o(pc_src_o), .branch_target_ex_o(target_o),
        .branch_decision_ex_o(dec_o), .trap_ex_o(trap_o),
        .alu_operation_id_i(alu_op), .rd_addr_id_i(rd), .mem_wen_id_i(wen),
        .mem_data_type_id_i(dtype), .mem_sign_extend_id_i(sext),
        .reg_alu_wen_id_i(wen), .reg_mem_wen_id_i(lwen), .pc_id_i(pc),
        .pc_source_id_i(pc_src), .is_branch_id_i(is_br),
        .alu_operand_1_id_i(op1), .alu_operand_2_id_i(op2), .mem_wdata_id_i(op1),
        .branch_target_id_i(target), .valid_id_i(valid), .csr_access_id_i(access),
        .csr_op_id_i(cop), .rd_addr_ex_o(rd_o), .alu_result_ex_o(result_o),
        .mem_wen_ex_o(mem_wen_o), .mem_data_type_ex_o(dtype_o),
        .mem_sign_extend_ex_o(sext_o), .mem_wdata_ex_o(mem_wdata_o),
        .reg_alu_wen_ex_o(alu_wen_o), .reg_mem_wen_ex_o(mem_rwen_o),
        .valid_ex_o(valid_o), .stall_ex_i(stall), .flush_ex_i(flush)
    );

    ////////////////////
    // Reference model
    ////////////////////

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            w = {w[30:0], lfsr[0]};
        end
        return w;
    endfunction

    function automatic logic [31:0] ref_alu(alu_operation_t op, logic [31:0] a, logic [31:0] b);
        logic lts;
        lts = $signed(a) < $signed(b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
            ALU_SLT, ALU_LT: return {31'b0, lts};
            ALU_SLTU, ALU_LTU: return {31'b0, a < b};
            ALU_EQ:   return {31'b0, a == b};
            ALU_NE:   return {31'b0, a != b};
            ALU_GE:   return {31'b0, !lts};
            default:  return {31'b0, a >= b};
        endcase
    endfunction

    function automatic int csr_index(logic [11:0] a);
        case (a)
            12'h300: return 0;
            12'h305: return 1;
            12'h340: return 2;
            12'h341: return 3;
            12'h342: return 4;
            default: return -1;
        endcase
    endfunction

    // Result, branch decision and trap of the modelled EX contents
    task automatic ex_model(output logic [31:0] res, output logic dec, output logic trap,
                            output logic ack, output int idx);
        idx = m_access ? csr_index(m_caddr) : -1;
        ack = m_valid && m_access && idx >= 0;
        res = ack ? shadow[idx] : ref_alu(m_op, m_a, m_b);
        dec = m_branch & res[0];
        trap = m_valid & dec & m_target[1];
    endtask

    ////////////////////
    // Stimulus helpers
    ////////////////////

    // Model the coming edge, queue the expectation, then move to edge + 1 ns
    task automatic advance(input int test);
        expect_t e;
        logic [31:0] res, nv;
        logic dec, trap, ack;
        int idx;
        ex_model(res, dec, trap, ack, idx);
        if (!stall) begin
            if (trap) begin
                shadow[3] = m_pc & ~32'd3;
                shadow[4] = 32'd0;
            end else if (ack && m_cop != CSR_READ) begin
                case (m_cop)
                    CSR_WRITE: nv = m_cwdata;
                    CSR_SET:   nv = shadow[idx] | m_cwdata;
                    default:   nv = shadow[idx] & ~m_cwdata;
                endcase
                shadow[idx] = (idx == 3) ? (nv & ~32'd3) : nv;
            end
            if (flush) begin
                {m_valid, m_wen, m_lwen, m_branch, m_access} = 5'b0;
            end else begin
                {m_valid, m_wen, m_lwen, m_branch, m_access} = {valid, wen, lwen, is_br, access};
                {m_op, m_a, m_b, m_target, m_pc} = {alu_op, op1, op2, target, pc};
                {m_rd, m_dtype, m_sext, m_pcsrc} = {rd, dtype, sext, pc_src};
                m_loaded = 1'b1;
                if (access) begin
                    m_cop = cop;
                    m_caddr = op2[11:0];
                    m_cwdata = op1;
                end
            end
        end
        ex_model(res, dec, trap, ack, idx);
        e = '{cycle + 1, test, m_loaded, res, m_valid, dec, trap, m_target, m_wen,
              m_lwen, m_rd, m_a, m_dtype, m_sext, m_pcsrc};
        exp_q.push_back(e);
        @(posedge clk);
        #1;
    endtask

    task automatic idle_inputs();
        {valid, access, is_br, wen, lwen, stall, flush} = 7'b0;
        cop = CSR_READ;
        alu_op = ALU_ADD;
    endtask

    task automatic csr_issue(input int t, csr_operation_t o, logic [11:0] a, logic [31:0] d);
        idle_inputs();
        {valid, access, cop, op1, op2} = {1'b1, 1'b1, o, d, {20'h0, a}};
        advance(t);
    endtask

    task automatic finish_test(input int t);
        idle_inputs();
        advance(t);
        advance(t);
        // Last expectation is compared on the coming falling edge
        @(posedge clk);
        #1;
        $display("test %s done, %0d errors", names[t], test_errs);
        test_errs = 0;
    endtask

    task automatic mismatch(input int t, string field, logic [31:0] e, logic [31:0] a);
        $display("ERR %s %s expected %h actual %h", names[t], field, e, a);
        errors++;
        test_errs++;
    endtask

    ////////////////////
    // Compare and timeout
    ////////////////////

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, DUT did not finish the tests", cycle);
            $display("Test failed");
            $finish;
        end
    end

    // Mid-cycle, outputs are settled
    always @(negedge clk) begin
        expect_t e;
        while (exp_q.size() > 0 && exp_q[0].due == cycle) begin
            e = exp_q.pop_front();
            checks++;
            if (valid_o !== e.valid) mismatch(e.test, "valid", 32'(e.valid), 32'(valid_o));
            if (alu_wen_o !== e.wen) mismatch(e.test, "reg_wen", 32'(e.wen), 32'(alu_wen_o));
            if (mem_wen_o !== e.wen) mismatch(e.test, "mem_wen", 32'(e.wen), 32'(mem_wen_o));
            if (mem_rwen_o !== e.lwen) begin
                mismatch(e.test, "load_wen", 32'(e.lwen), 32'(mem_rwen_o));
            end
            if (dec_o !== e.dec) mismatch(e.test, "branch", 32'(e.dec), 32'(dec_o));
            if (trap_o !== e.trap) mismatch(e.test, "trap", 32'(e.trap), 32'(trap_o));
            if (pc_src_o !== e.pcsrc) begin
                mismatch(e.test, "pc_source", 32'(e.pcsrc), 32'(pc_src_o));
            end
            if (e.loaded) begin
                if (result_o !== e.res) mismatch(e.test, "result", e.res, result_o);
                if (target_o !== e.target) mismatch(e.test, "target", e.target, target_o);
                if (rd_o !== e.rd) mismatch(e.test, "rd", 32'(e.rd), 32'(rd_o));
                if (mem_wdata_o !== e.wdata) mismatch(e.test, "wdata", e.wdata, mem_wdata_o);
                if (dtype_o !== e.dtype) begin
                    mismatch(e.test, "data_type", 32'(e.dtype), 32'(dtype_o));
                end
                if (sext_o !== e.sext) mismatch(e.test, "sign_ext", 32'(e.sext), 32'(sext_o));
            end
        end
    end

    ////////////////////
    // Tests
    ////////////////////

    initial begin
        logic [31:0] r;
        names = '{"reset", "alu_random", "stall_flush", "branch", "trap", "csr"};
        {cycle, checks, errors, test_errs} = '0;
        lfsr = 32'h96cc;
        {m_valid, m_wen, m_lwen, m_branch, m_access, m_loaded} = 6'b0;
        m_pcsrc = PC_NEXT;
        for (int i = 0; i < 5; i++) shadow[i] = '0;
        {op1, op2, target, pc} = '0;
        rd = '0;
        sext = 1'b0;
        dtype = WORD;
        pc_src = PC_NEXT;
        idle_inputs();
        wait (rst_n);
        // Reset values of the controls, before any edge loads the EX register
        if ({valid_o, mem_wen_o, alu_wen_o, mem_rwen_o, dec_o, trap_o} !== 6'b0) begin
            mismatch(0, "controls", 32'd0,
                     32'({valid_o, mem_wen_o, alu_wen_o, mem_rwen_o, dec_o, trap_o}));
        end
        if (pc_src_o !== PC_NEXT) mismatch(0, "pc_source", 32'(PC_NEXT), 32'(pc_src_o));
        @(posedge clk);
        #1;
        foreach (shadow[i]) csr_issue(0, CSR_READ, (i == 0) ? 12'h300 : (i == 1) ? 12'h305 :
                                      12'h33f + 12'(i - 1), 32'd0);
        finish_test(0);

        for (int i = 0; i < 200; i++) begin
            r = rand_bits(4);
            alu_op = alu_operation_t'(r[3:0]);
            op1 = rand_bits(32);
            op2 = rand_bits(32);
            // Pass-through fields toward MEM and IF
            r = rand_bits(11);
            rd = r[4:0];
            sext = r[5];
            lwen = r[6];
            dtype = data_type_t'(r[8:7] % 2'd3);
            pc_src = pc_source_t'(r[10:9] % 2'd3);
            {valid, wen} = 2'b11;
            advance(1);
        end
        finish_test(1);

        // Stall holds, flush bubbles, stalled CSR write commits once
        op1 = rand_bits(32);
        {valid, wen, lwen, alu_op} = {3'b111, ALU_XOR};
        advance(2);
        {stall, is_br, alu_op, op2} = {2'b11, ALU_NE, 32'h55};
        repeat (3) advance(2);
        {stall, flush} = 2'b01;
        advance(2);
        csr_issue(2, CSR_WRITE, 12'h340, 32'ha5a5_0001);
        idle_inputs();
        stall = 1'b1;
        repeat (3) advance(2);
        csr_issue(2, CSR_READ, 12'h340, 32'd0);
        finish_test(2);

        for (int i = 0; i < 40; i++) begin
            r = rand_bits(3);
            alu_op = alu_operation_t'(4'd10 + {1'b0, r[2:0]} % 4'd6);
            op1 = rand_bits(32);
            op2 = rand_bits(32);
            if (r[0]) op2 = op1;
            target = rand_bits(32);
            target[1:0] = 2'b00;
            {valid, is_br} = 2'b11;
            advance(3);
        end
        finish_test(3);

        csr_issue(4, CSR_WRITE, 12'h342, 32'd5);
        idle_inputs();
        {op1, op2, target, pc, alu_op, is_br} = {32'd7, 32'd7, 32'h2002, 32'h1236, ALU_EQ, 1'b1};
        advance(4);
        {valid, pc} = {1'b1, 32'h4567};
        advance(4);
        csr_issue(4, CSR_READ, 12'h341, 32'd0);
        csr_issue(4, CSR_READ, 12'h342, 32'd0);
        finish_test(4);

        for (int k = 0; k < 2; k++) begin
            r = rand_bits(32);
            csr_issue(5, CSR_WRITE, k ? 12'h305 : 12'h340, r);
            csr_issue(5, CSR_SET, k ? 12'h305 : 12'h340, 32'h0f0f_00f0);
            csr_issue(5, CSR_CLEAR, k ? 12'h305 : 12'h340, 32'hff00_0003);
            csr_issue(5, CSR_READ, k ? 12'h305 : 12'h340, 32'd0);
        end
        // Unimplemented address falls back to the ALU
        csr_issue(5, CSR_WRITE, 12'h7c0, 32'h1234_5678);
        finish_test(5);

        $display("closing: %0d checks, %0d errors", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
